/* Bender.yml */
package:
  name: modbus_wishbone_bridge

sources:
  - files:
      - source/modbusPkg.sv
      - source/requestIf.sv
      - source/modbusCrc.sv
      - source/frameReceiver.sv
      - source/responseSender.sv
      - source/modbusWishboneBridge.sv
  - target: test
    files:
      - bench/tbClock.sv
      - bench/bridge_asserts.sv
      - bench/modbusChecker.sv
      - bench/modbusTb.sv

/* bench/bridge_asserts.sv */
`timescale 1ns/1ps

module bridge_asserts (
    input logic clk,
    input logic rst,
    input logic [7:0] fifoData,
    input logic fifoWriteReq,
    input logic fifoWriteAck,
    input logic wbCyc,
    input logic wbStb,
    input logic wbWe
);

    int failures = 0;

    stbInsideCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
        else begin
            failures++;
            $error("wbStb high outside a Wishbone cycle");
        end

    // byte and request held while the fifo stalls
    fifoHeld: assert property (@(posedge clk) disable iff (rst)
        fifoWriteReq && !fifoWriteAck |=> fifoWriteReq && $stable(fifoData))
        else begin
            failures++;
            $error("FIFO request or data changed before the ack");
        end

    noWrites: assert property (@(posedge clk) disable iff (rst) !wbWe)
        else begin
            failures++;
            $error("wbWe raised on the read only bridge");
        end

endmodule

/* bench/modbusChecker.sv */
`timescale 1ns/1ps

module modbusChecker (
    input logic clk,
    input logic rst,
    input logic [7:0] fifoData,
    input logic fifoWriteReq,
    input logic fifoWriteAck,
    input modbusPkg::wbAddr_t wbAdr,
    input logic wbCyc,
    input logic wbStb,
    input logic wbAck
);
    import modbusPkg::*;

    logic [7:0] expQ[$];
    logic [7:0] expected;
    wbAddr_t addrQ[$];
    wbAddr_t expectedAddr;
    string testName = "reset";
    int byteIndex = 0;
    int testErrors = 0;
    int passCount = 0;
    int failCount = 0;

    task automatic beginTest(input string name);
        testName = name;
        byteIndex = 0;
        testErrors = 0;
        expQ.delete();
        addrQ.delete();
    endtask

    task automatic expectByte(input logic [7:0] value);
        expQ.push_back(value);
    endtask

    task automatic expectAddress(input wbAddr_t value);
        addrQ.push_back(value);
    endtask

    function automatic int pendingBytes();
        return expQ.size();
    endfunction

    task automatic endTest();
        if (expQ.size() != 0) begin
            $display("%s: %0d response bytes never arrived", testName, expQ.size());
            testErrors++;
            expQ.delete();
        end
        if (addrQ.size() != 0) begin
            $display("%s: %0d Wishbone reads never happened", testName, addrQ.size());
            testErrors++;
            addrQ.delete();
        end
        if (testErrors == 0) begin
            passCount++;
            $display("test %s passed, %0d bytes", testName, byteIndex);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", testName, testErrors);
        end
    endtask

    task automatic printSummary();
        $display("%0d tests run: %0d passed, %0d failed",
            passCount + failCount, passCount, failCount);
    endtask

    // one byte per acked fifo write
    always @(posedge clk) begin
        if (!rst && fifoWriteReq && fifoWriteAck) begin
            if (expQ.size() == 0) begin
                $display("%s: unexpected byte 0x%02h written to the FIFO", testName, fifoData);
                testErrors++;
            end else begin
                expected = expQ.pop_front();
                if (fifoData !== expected) begin
                    $display("FAIL %s byte %0d: expected 0x%02h, actual 0x%02h",
                        testName, byteIndex, expected, fifoData);
                    testErrors++;
                end
            end
            byteIndex++;
        end
    end

    // one register per acked wishbone read
    always @(posedge clk) begin
        if (!rst && wbCyc && wbStb && wbAck) begin
            if (addrQ.size() == 0) begin
                $display("%s: unexpected Wishbone read at 0x%06h", testName, wbAdr);
                testErrors++;
            end else begin
                expectedAddr = addrQ.pop_front();
                if (wbAdr !== expectedAddr) begin
                    $display("FAIL %s read address: expected 0x%06h, actual 0x%06h",
                        testName, expectedAddr, wbAdr);
                    testErrors++;
                end
            end
        end
    end

endmodule

/* bench/modbusTb.sv */
`timescale 1ns/1ps

module modbusTb;
    import modbusPkg::*;

    localparam int cyclesPerByte = 16; // worst input gap or fifo plus wishbone wait
    localparam int quietCycles = 40;
    localparam int testCount = 13;
    localparam int watchdogCycles = 2 * testCount * ((8 + 255) * cyclesPerByte + quietCycles);

    logic clk;
    logic rst;
    logic [7:0] uartData;
    logic uartDataReceived;
    logic parityError;
    logic silence;
    logic [7:0] fifoData;
    logic fifoWriteReq;
    logic fifoWriteAck;
    wbAddr_t wbAdr;
    regData_t wbDatIn;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic wbAck;

    integer seed = 32'ha029;
    int fifoDelay;
    int wbDelay;
    logic [7:0] refBytes [0:259];
    wbAddr_t refAddr [0:124];

    tbClock clock_i (.clk(clk), .rst(rst));
    modbusWishboneBridge dut_i (.*);
    modbusChecker checker_i (.*);
    bind modbusWishboneBridge bridge_asserts asserts_i (.*);

    function automatic logic [15:0] crcUpdate(input logic [15:0] crcIn, input logic [7:0] data);
        logic [15:0] c;
        c = crcIn ^ {8'h00, data};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
        end
        return c;
    endfunction

    // expected response into refBytes, read addresses into refAddr, returns its length
    function automatic int buildResponse(input logic [7:0] station, input logic [7:0] fn,
                                         input logic [15:0] start, input logic [15:0] qty,
                                         input logic parityBad);
        logic [7:0] exc;
        logic [15:0] crc;
        wbAddr_t addr;
        int n;
        if (station != stationAddress || parityBad) return 0;
        exc = 8'd0;
        if (fn != funReadHolding && fn != funReadInput) exc = excIllegalFunction;
        else if (qty == 16'd0 || qty > maxQuantity) exc = excIllegalValue;
        else if ({1'b0, start} + {1'b0, qty} > {1'b0, registerSpace}) exc = excIllegalAddress;
        refBytes[0] = stationAddress;
        refBytes[1] = (exc != 8'd0) ? (fn | 8'h80) : fn;
        refBytes[2] = (exc != 8'd0) ? exc : 8'(qty * 2);
        n = 3;
        for (int i = 0; exc == 8'd0 && i < qty; i++) begin
            addr = ((fn == funReadInput) ? inputOffset : holdingOffset) + 24'(start) + 24'(i);
            refAddr[i] = addr;
            refBytes[n] = addr[15:8] ^ 8'h5A;
            refBytes[n + 1] = addr[7:0] ^ 8'h5A;
            n = n + 2;
        end
        crc = 16'hFFFF;
        for (int i = 0; i < n; i++) crc = crcUpdate(crc, refBytes[i]);
        refBytes[n] = crc[7:0];
        refBytes[n + 1] = crc[15:8];
        return n + 2;
    endfunction

    task automatic sendFrame(input logic [7:0] station, input logic [7:0] fn,
                             input logic [15:0] start, input logic [15:0] qty, input int badByte);
        logic [63:0] frame;
        logic [15:0] crc;
        frame = {station, fn, start, qty, 16'h0000};
        crc = 16'hFFFF;
        for (int i = 0; i < 6; i++) crc = crcUpdate(crc, frame[63 - 8 * i -: 8]);
        frame[15:0] = {crc[7:0], crc[15:8]}; // crc low byte first
        silence = 1'b0;
        for (int i = 0; i < 8; i++) begin
            repeat ({$random(seed)} % 4) @(negedge clk);
            @(negedge clk);
            uartData = frame[63 - 8 * i -: 8];
            uartDataReceived = 1'b1;
            parityError = (i == badByte);
            @(negedge clk);
            uartDataReceived = 1'b0;
            parityError = 1'b0;
        end
        silence = 1'b1;
    endtask

    task automatic runTest(input string name, input logic [7:0] station, input logic [7:0] fn,
                           input logic [15:0] start, input logic [15:0] qty, input int badByte);
        int n;
        int waited;
        n = buildResponse(station, fn, start, qty, badByte >= 0);
        checker_i.beginTest(name);
        for (int i = 0; i < n; i++) checker_i.expectByte(refBytes[i]);
        for (int i = 0; i < (n - 5) / 2; i++) checker_i.expectAddress(refAddr[i]);
        sendFrame(station, fn, start, qty, badByte);
        waited = 0;
        while (checker_i.pendingBytes() != 0 && waited < (n + 8) * cyclesPerByte) begin
            @(negedge clk);
            waited++;
        end
        repeat (quietCycles) @(negedge clk); // stray bytes show up here
        checker_i.endTest();
    endtask

    // fifo acks after 0 to 4 cycles
    always @(negedge clk) begin
        if (rst) begin
            fifoWriteAck = 1'b0;
        end else if (fifoWriteAck) begin
            fifoWriteAck = 1'b0;
            fifoDelay = {$random(seed)} % 5;
        end else if (fifoWriteReq) begin
            if (fifoDelay == 0) fifoWriteAck = 1'b1;
            else fifoDelay--;
        end
    end

    // wishbone slave, data is address xor 0x5A5A
    always @(negedge clk) begin
        if (rst) begin
            wbAck = 1'b0;
        end else if (wbAck) begin
            wbAck = 1'b0;
            wbDelay = {$random(seed)} % 4;
        end else if (wbCyc && wbStb) begin
            if (wbDelay == 0) begin
                wbAck = 1'b1;
                wbDatIn = wbAdr[15:0] ^ 16'h5A5A;
            end else begin
                wbDelay--;
            end
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [15:0] start;
        logic [15:0] qty;
        uartData = 8'h00;
        uartDataReceived = 1'b0;
        parityError = 1'b0;
        silence = 1'b1;
        fifoWriteAck = 1'b0;
        wbAck = 1'b0;
        wbDatIn = '0;
        fifoDelay = 0;
        wbDelay = 0;
        @(negedge clk);
        while (rst) @(negedge clk);
        repeat (5) @(negedge clk);
        runTest("holdingQty1", stationAddress, funReadHolding, 16'h0010, 16'd1, -1);
        runTest("holdingQty10", stationAddress, funReadHolding, 16'h1234, 16'd10, -1);
        for (int k = 0; k < 3; k++) begin
            qty = 16'd1 + 16'({$random(seed)} % 125);
            start = $random(seed);
            if ({1'b0, start} + {1'b0, qty} > 17'h0FFFF) start = 16'hFFFF - qty;
            runTest($sformatf("inputRandom%0d", k), stationAddress, funReadInput, start, qty, -1);
        end
        runTest("inputQty125", stationAddress, funReadInput, 16'hFF82, 16'd125, -1); // ends at 0xFFFF
        runTest("illegalFunction", stationAddress, 8'h06, 16'h0000, 16'd1, -1);
        runTest("quantityZero", stationAddress, funReadHolding, 16'h0000, 16'd0, -1);
        runTest("quantity126", stationAddress, funReadHolding, 16'hFFF0, 16'd126, -1);
        runTest("addressRange", stationAddress, funReadHolding, 16'hFFF0, 16'h0020, -1);
        runTest("foreignStation", 8'h12, funReadHolding, 16'h0000, 16'd4, -1);
        runTest("parityError", stationAddress, funReadHolding, 16'h0000, 16'd4, 1);
        runTest("afterIgnored", stationAddress, funReadInput, 16'h0100, 16'd3, -1);
        checker_i.printSummary();
        if (checker_i.failCount == 0 && dut_i.asserts_i.failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* bench/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* source/frameReceiver.sv */
`timescale 1ns/1ps

module frameReceiver (
    input logic clk,
    input logic rst,
    input logic [7:0] uartData,
    input logic uartDataReceived,
    input logic parityError,
    input logic silence,
    requestIf.receiver req
);
    import modbusPkg::*;

    logic [3:0] state;
    logic [7:0] addrHi;
    logic [7:0] qtyHi;
    logic [15:0] qtyNow;
    logic [16:0] endAddress;
    logic qtyBad;
    logic rangeBad;
    logic functionOk;

    assign qtyNow = {qtyHi, uartData}; // quantity as the low byte arrives
    assign qtyBad = (qtyNow == 16'd0) || (qtyNow > maxQuantity);
    assign endAddress = {1'b0, req.startAddress} + {1'b0, qtyNow};
    assign rangeBad = endAddress > {1'b0, registerSpace};
    assign functionOk = (uartData == funReadHolding) || (uartData == funReadInput);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rxStation;
            req.start <= 1'b0;
            req.error <= 1'b0;
        end else begin
            req.start <= 1'b0;
            if (silence) begin
                state <= rxStation;
            end else if (state == rxError) begin
                state <= rxWait; // request already issued
            end else if (uartDataReceived) begin
                if (parityError) begin
                    state <= rxWait;
                end else begin
                    case (state)
                        rxStation: begin
                            // sender still answering, drop this frame
                            if (uartData == stationAddress && !req.busy) begin
                                state <= rxFunction;
                            end else begin
                                state <= rxWait;
                            end
                        end
                        rxFunction: begin
                            req.functionCode <= uartData;
                            if (functionOk) begin
                                state <= rxAddrHi;
                            end else begin
                                state <= rxError;
                                req.start <= 1'b1;
                                req.error <= 1'b1;
                                req.exceptionCode <= excIllegalFunction;
                            end
                        end
                        rxAddrHi: begin
                            addrHi <= uartData;
                            state <= rxAddrLo;
                        end
                        rxAddrLo: begin
                            req.startAddress <= {addrHi, uartData};
                            state <= rxQtyHi;
                        end
                        rxQtyHi: begin
                            qtyHi <= uartData;
                            state <= rxQtyLo;
                        end
                        rxQtyLo: begin
                            req.quantity <= qtyNow;
                            if (qtyBad) begin // quantity wins over range
                                state <= rxError;
                                req.start <= 1'b1;
                                req.error <= 1'b1;
                                req.exceptionCode <= excIllegalValue;
                            end else if (rangeBad) begin
                                state <= rxError;
                                req.start <= 1'b1;
                                req.error <= 1'b1;
                                req.exceptionCode <= excIllegalAddress;
                            end else begin
                                state <= rxCrcLo;
                            end
                        end
                        rxCrcLo: begin
                            state <= rxCrcHi; // crc bytes are not checked
                        end
                        rxCrcHi: begin
                            state <= rxWait;
                            req.start <= 1'b1;
                            req.error <= 1'b0;
                        end
                        default: begin
                            state <= rxWait;
                        end
                    endcase
                end
            end
        end
    end

endmodule

/* source/modbusCrc.sv */
`timescale 1ns/1ps

module modbusCrc (
    input logic clk,
    input logic rst,
    input logic clear,
    input logic enable,
    input logic [7:0] data,
    output logic [15:0] crc
);
    import modbusPkg::*;

    logic [15:0] nextCrc;

    // one byte, lsb first
    always_comb begin
        nextCrc = crc ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            if (nextCrc[0]) begin
                nextCrc = (nextCrc >> 1) ^ crcPolynomial;
            end else begin
                nextCrc = nextCrc >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= crcInit;
        end else if (enable) begin
            crc <= nextCrc;
        end
    end

endmodule

/* source/modbusPkg.sv */
package modbusPkg;

    localparam int addrWidth = 24;
    localparam int dataWidth = 16;

    typedef logic [addrWidth-1:0] wbAddr_t;
    typedef logic [dataWidth-1:0] regData_t;

    localparam logic [7:0] stationAddress = 8'h37;

    localparam logic [7:0] funReadHolding = 8'h03;
    localparam logic [7:0] funReadInput = 8'h04;

    localparam logic [15:0] maxQuantity = 16'd125;
    localparam logic [15:0] registerSpace = 16'hFFFF; // highest start + quantity

    localparam wbAddr_t holdingOffset = 24'hA00000;
    localparam wbAddr_t inputOffset = 24'hA10000;

    localparam logic [7:0] excIllegalFunction = 8'd1;
    localparam logic [7:0] excIllegalAddress = 8'd2;
    localparam logic [7:0] excIllegalValue = 8'd3;

    localparam logic [15:0] crcInit = 16'hFFFF;
    localparam logic [15:0] crcPolynomial = 16'hA001; // reflected 0x8005

    // receiver FSM
    localparam logic [3:0] rxStation = 4'd0;
    localparam logic [3:0] rxFunction = 4'd1;
    localparam logic [3:0] rxAddrHi = 4'd2;
    localparam logic [3:0] rxAddrLo = 4'd3;
    localparam logic [3:0] rxQtyHi = 4'd4;
    localparam logic [3:0] rxQtyLo = 4'd5;
    localparam logic [3:0] rxCrcLo = 4'd6;
    localparam logic [3:0] rxCrcHi = 4'd7;
    localparam logic [3:0] rxError = 4'd8;
    localparam logic [3:0] rxWait = 4'd9;

    // sender FSM
    localparam logic [3:0] txIdle = 4'd0;
    localparam logic [3:0] txStation = 4'd1;
    localparam logic [3:0] txFunction = 4'd2;
    localparam logic [3:0] txException = 4'd3;
    localparam logic [3:0] txByteCount = 4'd4;
    localparam logic [3:0] txWbRead = 4'd5;
    localparam logic [3:0] txDataHi = 4'd6;
    localparam logic [3:0] txDataLo = 4'd7;
    localparam logic [3:0] txCrcLo = 4'd8;
    localparam logic [3:0] txCrcHi = 4'd9;

    typedef union packed {
        logic [7:0] plain;
        struct packed {
            logic exception; // set in exception responses
            logic [6:0] code;
        } flagged;
    } functionByte_t;

endpackage

/* source/modbusWishboneBridge.sv */
`timescale 1ns/1ps

module modbusWishboneBridge (
    input logic clk,
    input logic rst,
    // uart receiver
    input logic [7:0] uartData,
    input logic uartDataReceived,
    input logic parityError,
    input logic silence,
    // output fifo
    output logic [7:0] fifoData,
    output logic fifoWriteReq,
    input logic fifoWriteAck,
    // wishbone master
    output modbusPkg::wbAddr_t wbAdr,
    input modbusPkg::regData_t wbDatIn,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    input logic wbAck
);

    requestIf reqBus ();

    assign wbWe = 1'b0; // read only bridge

    frameReceiver receiver_i (
        .clk(clk),
        .rst(rst),
        .uartData(uartData),
        .uartDataReceived(uartDataReceived),
        .parityError(parityError),
        .silence(silence),
        .req(reqBus.receiver)
    );

    responseSender sender_i (
        .clk(clk),
        .rst(rst),
        .req(reqBus.sender),
        .fifoData(fifoData),
        .fifoWriteReq(fifoWriteReq),
        .fifoWriteAck(fifoWriteAck),
        .wbAdr(wbAdr),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbDatIn(wbDatIn),
        .wbAck(wbAck)
    );

endmodule

/* source/requestIf.sv */
`timescale 1ns/1ps

interface requestIf;

    logic [7:0] functionCode;
    logic [15:0] startAddress;
    logic [15:0] quantity;
    logic error;
    logic [7:0] exceptionCode;
    logic start; // one-cycle pulse
    logic busy;

    modport receiver (
        output functionCode,
        output startAddress,
        output quantity,
        output error,
        output exceptionCode,
        output start,
        input busy
    );

    modport sender (
        input functionCode,
        input startAddress,
        input quantity,
        input error,
        input exceptionCode,
        input start,
        output busy
    );

endinterface

/* source/responseSender.sv */
`timescale 1ns/1ps

module responseSender (
    input logic clk,
    input logic rst,
    requestIf.sender req,
    output logic [7:0] fifoData,
    output logic fifoWriteReq,
    input logic fifoWriteAck,
    output modbusPkg::wbAddr_t wbAdr,
    output logic wbCyc,
    output logic wbStb,
    input modbusPkg::regData_t wbDatIn,
    input logic wbAck
);
    import modbusPkg::*;

    logic [3:0] state;
    logic [7:0] dataReg;
    logic [7:0] lowByte;
    logic [6:0] regsLeft;
    wbAddr_t baseAddress;
    functionByte_t functionByte;
    logic crcClear;
    logic crcEnable;
    logic [15:0] crc;
    logic inCrc;

    assign req.busy = (state != txIdle);

    always_comb begin
        functionByte.flagged.exception = req.error;
        functionByte.flagged.code = req.functionCode[6:0];
    end

    assign baseAddress = (req.functionCode == funReadInput) ? inputOffset : holdingOffset;

    assign inCrc = (state == txCrcLo) || (state == txCrcHi);
    assign crcClear = (state == txIdle);
    assign crcEnable = fifoWriteReq && fifoWriteAck && !inCrc; // every acked byte but the crc

    // crc bytes straight from the accumulator, it is frozen by then
    always_comb begin
        case (state)
            txCrcLo: fifoData = crc[7:0];
            txCrcHi: fifoData = crc[15:8];
            default: fifoData = dataReg;
        endcase
    end

    modbusCrc crc_i (
        .clk(clk),
        .rst(rst),
        .clear(crcClear),
        .enable(crcEnable),
        .data(fifoData),
        .crc(crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= txIdle;
            fifoWriteReq <= 1'b0;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
        end else begin
            case (state)
                txIdle: begin
                    if (req.start) begin
                        state <= txStation;
                        fifoWriteReq <= 1'b1;
                        dataReg <= stationAddress;
                    end
                end
                txStation: begin
                    if (fifoWriteAck) begin
                        state <= txFunction;
                        dataReg <= functionByte.plain;
                    end
                end
                txFunction: begin
                    if (fifoWriteAck) begin
                        if (req.error) begin
                            state <= txException;
                            dataReg <= req.exceptionCode;
                        end else begin
                            state <= txByteCount;
                            dataReg <= {req.quantity[6:0], 1'b0};
                        end
                    end
                end
                txException: begin
                    if (fifoWriteAck) begin
                        state <= txCrcLo;
                    end
                end
                txByteCount: begin
                    if (fifoWriteAck) begin
                        state <= txWbRead;
                        fifoWriteReq <= 1'b0;
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                        wbAdr <= baseAddress + wbAddr_t'(req.startAddress);
                        regsLeft <= req.quantity[6:0];
                    end
                end
                txWbRead: begin
                    if (wbAck) begin
                        state <= txDataHi;
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        fifoWriteReq <= 1'b1;
                        dataReg <= wbDatIn[15:8];
                        lowByte <= wbDatIn[7:0];
                    end
                end
                txDataHi: begin
                    if (fifoWriteAck) begin
                        state <= txDataLo;
                        dataReg <= lowByte;
                    end
                end
                txDataLo: begin
                    if (fifoWriteAck) begin
                        regsLeft <= regsLeft - 7'd1;
                        if (regsLeft == 7'd1) begin
                            state <= txCrcLo;
                        end else begin // next register
                            state <= txWbRead;
                            fifoWriteReq <= 1'b0;
                            wbCyc <= 1'b1;
                            wbStb <= 1'b1;
                            wbAdr <= wbAdr + 1'b1;
                        end
                    end
                end
                txCrcLo: begin
                    if (fifoWriteAck) begin
                        state <= txCrcHi;
                    end
                end
                txCrcHi: begin
                    if (fifoWriteAck) begin
                        state <= txIdle;
                        fifoWriteReq <= 1'b0;
                    end
                end
                default: begin
                    state <= txIdle;
                    fifoWriteReq <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* verilog.f */
source/modbusPkg.sv
source/requestIf.sv
source/modbusCrc.sv
source/frameReceiver.sv
source/responseSender.sv
source/modbusWishboneBridge.sv
bench/tbClock.sv
bench/bridge_asserts.sv
bench/modbusChecker.sv
bench/modbusTb.sv
